// File: source/br_macros.svh
`ifndef BR_MACROS_SVH
`define BR_MACROS_SVH

// btb geometry, indexed by pc word address.
`define BTB_INDEX_BITS 8
`define BTB_DEPTH      256

// rename tag width.
`define PHYS_REG_BITS  6

// branch issue queue.
`define BRQ_DEPTH      4

`endif

// File: source/rv32i_types.sv
`default_nettype none

`include "br_macros.svh"

package rv32i_types;

    typedef logic [31:0]                  word_t;
    typedef logic [`PHYS_REG_BITS-1:0]    phys_reg_t;
    typedef logic [`BTB_INDEX_BITS-1:0]   btb_index_t;

    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        branch_f3_beq  = 3'b000,
        branch_f3_bne  = 3'b001,
        branch_f3_blt  = 3'b100,
        branch_f3_bge  = 3'b101,
        branch_f3_bltu = 3'b110,
        branch_f3_bgeu = 3'b111
    } branch_funct3_t;

    typedef struct packed {
        rv32i_opcode_t  opcode;
        branch_funct3_t funct3;
        word_t          pc;
        word_t          i_imm;
        word_t          b_imm;
        word_t          j_imm;
        logic           bp;         // fetch predicted taken.
        word_t          bp_addr;    // fetch predicted target.
    } decode_info_t;

    typedef struct packed {
        decode_info_t   decode_info;
        word_t          rs1_v;
        word_t          rs2_v;
        phys_reg_t      pd;
    } br_op_t;

    typedef struct packed {
        phys_reg_t      pd;
        word_t          rd_v;
        logic           redirect;
        word_t          redirect_pc;
    } br_result_t;

    typedef struct packed {
        logic           web;        // active low.
        btb_index_t     addr;
        word_t          din;
    } btb_write_t;

endpackage : rv32i_types

`default_nettype wire

// File: source/br_issue_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "br_macros.svh"

module br_issue_queue
import rv32i_types::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   dispatch_valid,
    input  br_op_t dispatch_op,
    output logic   dispatch_ready,
    output logic   start,
    output br_op_t issue_op
);

    localparam int PTR_BITS = $clog2(`BRQ_DEPTH);

    br_op_t                entries [`BRQ_DEPTH];
    logic [PTR_BITS-1:0]   head;
    logic [PTR_BITS-1:0]   tail;
    logic [PTR_BITS:0]     count;

    logic                  push;
    logic                  pop;

    assign dispatch_ready = (count != (PTR_BITS+1)'(`BRQ_DEPTH));
    assign push           = dispatch_valid && dispatch_ready;
    assign pop            = (count != '0);  // fu_br never stalls.

    assign start    = pop;
    assign issue_op = entries[head];

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        logic [PTR_BITS-1:0] nxt;
        if (ptr == PTR_BITS'(`BRQ_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // payload storage.
    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= dispatch_op;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                tail <= ptr_inc(tail);
            end
            if (pop) begin
                head <= ptr_inc(head);
            end
        end
    end

    // occupancy, unchanged on simultaneous push and pop.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            unique case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : br_issue_queue

`default_nettype wire

// File: source/fu_br.sv
`timescale 1ns/1ns
`default_nettype none

`include "br_macros.svh"

module fu_br
import rv32i_types::*;
(
    input  word_t        rs1_v,
    input  word_t        rs2_v,
    input  decode_info_t decode_info,
    input  logic         start,
    output word_t        rd_v,
    output logic         valid,
    output logic         busy,
    output logic         pc_select,
    output word_t        pc_branch,
    output btb_write_t   btb_wr
);

    logic signed [31:0] as;
    logic signed [31:0] bs;

    logic   br_en;
    logic   is_xfer;        // jal, jalr or conditional branch.
    logic   taken;
    word_t  target;
    word_t  seq_pc;

    assign as     = signed'(rs1_v);
    assign bs     = signed'(rs2_v);
    assign seq_pc = decode_info.pc + 32'd4;

    assign valid = start;
    assign busy  = start;   // single cycle, never holds off the queue.

    always_comb begin
        case (decode_info.funct3)
            branch_f3_beq:  br_en = (rs1_v == rs2_v);
            branch_f3_bne:  br_en = (rs1_v != rs2_v);
            branch_f3_blt:  br_en = (as < bs);
            branch_f3_bge:  br_en = (as >= bs);
            branch_f3_bltu: br_en = (rs1_v < rs2_v);
            branch_f3_bgeu: br_en = (rs1_v >= rs2_v);
            default:        br_en = 1'b0;   // reserved encodings fall through.
        endcase
    end

    // actual outcome.
    always_comb begin
        rd_v    = '0;
        is_xfer = 1'b0;
        taken   = 1'b0;
        target  = '0;
        if (start) begin
            case (decode_info.opcode)
                op_b_jal: begin
                    is_xfer = 1'b1;
                    rd_v    = seq_pc;
                    taken   = 1'b1;
                    target  = decode_info.pc + decode_info.j_imm;
                end
                op_b_jalr: begin
                    is_xfer = 1'b1;
                    rd_v    = seq_pc;
                    taken   = 1'b1;
                    target  = (rs1_v + decode_info.i_imm) & 32'hffff_fffe;
                end
                op_b_br: begin
                    is_xfer = 1'b1;
                    taken   = br_en;
                    target  = br_en ? decode_info.pc + decode_info.b_imm : '0;
                end
                default: begin
                end
            endcase
        end
    end

    // btb learns every taken transfer.
    always_comb begin
        btb_wr.web  = ~taken;
        btb_wr.addr = taken ? decode_info.pc[`BTB_INDEX_BITS+1:2] : '0;
        btb_wr.din  = taken ? target : '0;
    end

    // compare against the fetch prediction.
    always_comb begin
        pc_select = taken;
        pc_branch = target;
        if (is_xfer && decode_info.bp) begin
            if (!taken) begin
                pc_select = 1'b1;
                pc_branch = seq_pc;
            end else if (target == decode_info.bp_addr) begin
                pc_select = 1'b0;
                pc_branch = '0;
            end
        end
    end

endmodule : fu_br

`default_nettype wire

// File: source/btb.sv
`timescale 1ns/1ns
`default_nettype none

`include "br_macros.svh"

module btb
import rv32i_types::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  btb_write_t btb_wr,
    input  btb_index_t rd_index,
    input  logic       rd_en,
    output logic       rd_hit,
    output word_t      rd_target
);

    word_t                   targets [`BTB_DEPTH];
    logic [`BTB_DEPTH-1:0]   entry_valid;

    // target array.
    always_ff @(posedge clk) begin
        if (!btb_wr.web) begin
            targets[btb_wr.addr] <= btb_wr.din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (!btb_wr.web) begin
            entry_valid[btb_wr.addr] <= 1'b1;
        end
    end

    // registered read, sees contents from before a same-cycle write.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_hit <= 1'b0;
        end else if (rd_en) begin
            rd_hit <= entry_valid[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_target <= targets[rd_index];
        end
    end

endmodule : btb

`default_nettype wire

// File: source/branch_predict.sv
`timescale 1ns/1ns
`default_nettype none

`include "br_macros.svh"

module branch_predict
import rv32i_types::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fetch_valid,
    input  word_t      fetch_pc,
    output btb_index_t btb_rd_index,
    output logic       btb_rd_en,
    input  logic       btb_hit,
    input  word_t      btb_target,
    output logic       pred_valid,
    output logic       pred_taken,
    output word_t      pred_target
);

    word_t seq_pc_q;    // fall-through address of the looked-up pc.

    // lookup is issued in the fetch cycle, the btb answers one cycle later.
    assign btb_rd_index = fetch_pc[`BTB_INDEX_BITS+1:2];
    assign btb_rd_en    = fetch_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            seq_pc_q <= fetch_pc + 32'd4;
        end
    end

    always_comb begin
        pred_taken  = pred_valid && btb_hit;
        pred_target = seq_pc_q;
        if (pred_taken) begin
            pred_target = btb_target;
        end
    end

endmodule : branch_predict

`default_nettype wire

// File: source/br_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module br_writeback
import rv32i_types::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid,
    input  phys_reg_t  pd,
    input  word_t      rd_v,
    input  logic       pc_select,
    input  word_t      pc_branch,
    output logic       wb_valid,
    output br_result_t wb_result
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= valid;
        end
    end

    // payload holds between results.
    always_ff @(posedge clk) begin
        if (valid) begin
            wb_result.pd          <= pd;
            wb_result.rd_v        <= rd_v;
            wb_result.redirect    <= pc_select;
            wb_result.redirect_pc <= pc_branch;
        end
    end

endmodule : br_writeback

`default_nettype wire

// File: source/branch_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit_top
import rv32i_types::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dispatch_valid,
    input  br_op_t     dispatch_op,
    output logic       dispatch_ready,
    output logic       wb_valid,
    output br_result_t wb_result,
    input  logic       fetch_valid,
    input  word_t      fetch_pc,
    output logic       pred_valid,
    output logic       pred_taken,
    output word_t      pred_target
);

    logic       issue_start;
    br_op_t     issue_op;
    word_t      fu_rd_v;
    logic       fu_valid;
    logic       fu_pc_select;
    word_t      fu_pc_branch;
    btb_write_t btb_wr;
    btb_index_t btb_rd_index;
    logic       btb_rd_en;
    logic       btb_hit;
    word_t      btb_target;

    br_issue_queue u_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_ready (dispatch_ready),
        .start          (issue_start),
        .issue_op       (issue_op)
    );

    fu_br u_fu_br (
        .rs1_v       (issue_op.rs1_v),
        .rs2_v       (issue_op.rs2_v),
        .decode_info (issue_op.decode_info),
        .start       (issue_start),
        .rd_v        (fu_rd_v),
        .valid       (fu_valid),
        .busy        (),
        .pc_select   (fu_pc_select),
        .pc_branch   (fu_pc_branch),
        .btb_wr      (btb_wr)
    );

    btb u_btb (
        .clk       (clk),
        .rst_n     (rst_n),
        .btb_wr    (btb_wr),
        .rd_index  (btb_rd_index),
        .rd_en     (btb_rd_en),
        .rd_hit    (btb_hit),
        .rd_target (btb_target)
    );

    branch_predict u_predict (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .btb_rd_index (btb_rd_index),
        .btb_rd_en    (btb_rd_en),
        .btb_hit      (btb_hit),
        .btb_target   (btb_target),
        .pred_valid   (pred_valid),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target)
    );

    br_writeback u_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (fu_valid),
        .pd        (issue_op.pd),
        .rd_v      (fu_rd_v),
        .pc_select (fu_pc_select),
        .pc_branch (fu_pc_branch),
        .wb_valid  (wb_valid),
        .wb_result (wb_result)
    );

endmodule : branch_unit_top

`default_nettype wire

// File: verif/br_model.svh
`ifndef BR_MODEL_SVH
`define BR_MODEL_SVH

// shadow copy of the btb, updated as each taken transfer retires.
logic  shadow_valid  [`BTB_DEPTH];
word_t shadow_target [`BTB_DEPTH];

function automatic logic is_transfer(input br_op_t op);
    return (op.decode_info.opcode == op_b_jal) || (op.decode_info.opcode == op_b_jalr) ||
           (op.decode_info.opcode == op_b_br);
endfunction

function automatic logic cond_holds(input branch_funct3_t f3, input word_t a, input word_t b);
    logic res;
    case (f3)
        branch_f3_beq:  res = (a == b);
        branch_f3_bne:  res = (a != b);
        branch_f3_blt:  res = ($signed(a) < $signed(b));
        branch_f3_bge:  res = ($signed(a) >= $signed(b));
        branch_f3_bltu: res = (a < b);
        branch_f3_bgeu: res = (a >= b);
        default:        res = 1'b0;
    endcase
    return res;
endfunction

function automatic logic actual_taken(input br_op_t op);
    logic res;
    case (op.decode_info.opcode)
        op_b_jal, op_b_jalr: res = 1'b1;
        op_b_br:             res = cond_holds(op.decode_info.funct3, op.rs1_v, op.rs2_v);
        default:             res = 1'b0;
    endcase
    return res;
endfunction

function automatic word_t actual_target(input br_op_t op);
    word_t sum;
    word_t res;
    sum = op.rs1_v + op.decode_info.i_imm;
    case (op.decode_info.opcode)
        op_b_jal:  res = op.decode_info.pc + op.decode_info.j_imm;
        op_b_jalr: res = {sum[31:1], 1'b0};
        op_b_br:   res = op.decode_info.pc + op.decode_info.b_imm;
        default:   res = '0;
    endcase
    return res;
endfunction

function automatic br_result_t expected_result(input br_op_t op);
    br_result_t res;
    logic       taken;
    word_t      tgt;
    word_t      link;
    taken           = actual_taken(op);
    tgt             = actual_target(op);
    link            = op.decode_info.pc + 32'd4;
    res.pd          = op.pd;
    res.rd_v        = (op.decode_info.opcode == op_b_br || !is_transfer(op)) ? '0 : link;
    res.redirect    = 1'b0;
    res.redirect_pc = '0;
    if (is_transfer(op)) begin
        if (!op.decode_info.bp) begin
            res.redirect    = taken;
            res.redirect_pc = taken ? tgt : '0;
        end else if (!taken) begin
            res.redirect    = 1'b1;
            res.redirect_pc = link;
        end else if (tgt != op.decode_info.bp_addr) begin
            res.redirect    = 1'b1;
            res.redirect_pc = tgt;
        end
    end
    return res;
endfunction

function automatic void shadow_record(input br_op_t op);
    btb_index_t idx;
    idx = op.decode_info.pc[`BTB_INDEX_BITS+1:2];
    if (actual_taken(op)) begin
        shadow_valid[idx]  = 1'b1;
        shadow_target[idx] = actual_target(op);
    end
endfunction

function automatic word_t shadow_next(input word_t pc);
    btb_index_t idx;
    idx = pc[`BTB_INDEX_BITS+1:2];
    return shadow_valid[idx] ? shadow_target[idx] : pc + 32'd4;
endfunction

`endif

// File: verif/tb_branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "br_macros.svh"

module tb_branch_unit
import rv32i_types::*;
();

    localparam int NUM_OPS        = 400;
    localparam int DISPATCH_LIMIT = 4000;
    localparam int DRAIN_LIMIT    = 40;

    logic       clk;
    logic       rst_n;
    logic       dispatch_valid;
    br_op_t     dispatch_op;
    logic       dispatch_ready;
    logic       wb_valid;
    br_result_t wb_result;
    logic       fetch_valid;
    word_t      fetch_pc;
    logic       pred_valid;
    logic       pred_taken;
    word_t      pred_target;

    logic [31:0] lfsr_state;
    br_op_t      pending [$];   // dispatched, not yet written back.
    int          model_cnt;
    int          gen_count;
    int          accepted;
    int          results;
    int          checks;
    int          errors;
    int          ready_low;
    int          burst_left;
    int          cycles;
    logic        issued_last;
    logic        pushed_last;
    logic        lookup_pend;
    logic        exp_hit;
    word_t       exp_target;
    logic        timed_out;

    `include "br_model.svh"

    branch_unit_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_ready (dispatch_ready),
        .wb_valid       (wb_valid),
        .wb_result      (wb_result),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .pred_valid     (pred_valid),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target)
    );

    always #2 clk = ~clk;

    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // biased toward zero and the signed and unsigned extremes.
    function automatic word_t make_operand();
        word_t sel;
        word_t v;
        sel = rand_bits(3);
        case (sel[2:0])
            3'd0:    v = 32'h0000_0000;
            3'd1:    v = 32'h7fff_ffff;
            3'd2:    v = 32'h8000_0000;
            3'd3:    v = 32'hffff_ffff;
            default: v = rand_bits(32);
        endcase
        return v;
    endfunction

    function automatic br_op_t make_op();
        br_op_t op;
        word_t  r;
        op = '0;
        r  = rand_bits(4);
        if (r[3:0] < 4'd2) begin
            op.decode_info.opcode = op_b_jal;
        end else if (r[3:0] < 4'd4) begin
            op.decode_info.opcode = op_b_jalr;
        end else if (r[3:0] < 4'd12) begin
            op.decode_info.opcode = op_b_br;
        end else if (r[3:0] == 4'd12) begin
            op.decode_info.opcode = op_b_lui;
        end else if (r[3:0] == 4'd13) begin
            op.decode_info.opcode = op_b_auipc;
        end else begin
            op.decode_info.opcode = op_b_load;
        end
        r = rand_bits(3);
        case (r[2:0])
            3'd0:    op.decode_info.funct3 = branch_f3_beq;
            3'd1:    op.decode_info.funct3 = branch_f3_bne;
            3'd2:    op.decode_info.funct3 = branch_f3_blt;
            3'd3:    op.decode_info.funct3 = branch_f3_bge;
            3'd4:    op.decode_info.funct3 = branch_f3_bltu;
            default: op.decode_info.funct3 = branch_f3_bgeu;
        endcase
        op.rs1_v = make_operand();
        r        = rand_bits(2);
        op.rs2_v = (r[1:0] == 2'd0) ? op.rs1_v : make_operand();
        r        = rand_bits(30);
        op.decode_info.pc = {r[29:0], 2'b00};
        r = rand_bits(12);
        op.decode_info.i_imm = {{20{r[11]}}, r[11:0]};
        r = rand_bits(12);
        op.decode_info.b_imm = {{19{r[11]}}, r[11:0], 1'b0};
        r = rand_bits(20);
        op.decode_info.j_imm = {{11{r[19]}}, r[19:0], 1'b0};
        r = rand_bits(3);
        op.decode_info.bp      = r[2];
        op.decode_info.bp_addr = (r[1:0] != 2'd0) ? actual_target(op) : rand_bits(32);
        r     = rand_bits(6);
        op.pd = r[5:0];
        return op;
    endfunction

    function automatic logic pick_offer();
        word_t r;
        logic  offer;
        if (burst_left > 0) begin
            burst_left = burst_left - 1;
            offer      = 1'b1;
        end else begin
            r = rand_bits(3);
            if (r[2:0] == 3'd0) begin
                r          = rand_bits(4);
                burst_left = int'(r[3:0]) + 4;
                offer      = 1'b1;
            end else begin
                offer = r[0];
            end
        end
        return offer;
    endfunction

    task automatic run_cycle(input logic offer);
        br_op_t     done_op;
        br_result_t exp;
        word_t      r;
        @(posedge clk);
        #1;
        if (issued_last) model_cnt = model_cnt - 1;
        if (pushed_last) model_cnt = model_cnt + 1;
        done_op = '0;
        checks++;
        assert (wb_valid == issued_last) else begin
            errors++;
            $display("ERROR @%0t: wb_valid %0b, expected %0b", $time, wb_valid, issued_last);
        end
        if (wb_valid) begin
            checks++;
            assert (pending.size() > 0) else begin
                errors++;
                $display("writeback produced a result with no operation outstanding");
            end
        end
        if (wb_valid && pending.size() > 0) begin
            done_op = pending.pop_front();
            exp     = expected_result(done_op);
            results++;
            checks++;
            assert (wb_result == exp) else begin
                errors++;
                $display("ERROR @%0t: got %0h/%h/%0b/%h, want %0h/%h/%0b/%h (pd/rd_v/redir/pc)",
                         $time, wb_result.pd, wb_result.rd_v, wb_result.redirect,
                         wb_result.redirect_pc, exp.pd, exp.rd_v, exp.redirect, exp.redirect_pc);
            end
            shadow_record(done_op);
        end
        checks++;
        assert (pred_valid == lookup_pend) else begin
            errors++;
            $display("ERROR @%0t: pred_valid %0b, expected %0b", $time, pred_valid, lookup_pend);
        end
        if (lookup_pend) begin
            checks++;
            assert (pred_taken == exp_hit && pred_target == exp_target) else begin
                errors++;
                $display("ERROR @%0t: prediction %0b/%h, expected %0b/%h", $time,
                         pred_taken, pred_target, exp_hit, exp_target);
            end
        end
        checks++;
        assert (dispatch_ready == (model_cnt != `BRQ_DEPTH)) else begin
            errors++;
            $display("ERROR @%0t: dispatch_ready %0b with %0d queued", $time,
                     dispatch_ready, model_cnt);
        end
        if (!dispatch_ready) ready_low++;
        issued_last = (model_cnt > 0);
        // op is held until the queue takes it.
        if (!dispatch_valid || pushed_last) begin
            if (offer && gen_count < NUM_OPS) begin
                dispatch_op    = make_op();
                dispatch_valid = 1'b1;
                gen_count++;
            end else begin
                dispatch_valid = 1'b0;
            end
        end
        pushed_last = dispatch_valid && dispatch_ready;
        if (pushed_last) begin
            pending.push_back(dispatch_op);
            accepted++;
        end
        r           = rand_bits(2);
        lookup_pend = wb_valid || (r[1:0] == 2'd0);
        fetch_valid = lookup_pend;
        if (lookup_pend) begin
            r          = rand_bits(32);
            fetch_pc   = (wb_valid && r[0]) ? done_op.decode_info.pc : {r[31:2], 2'b00};
            exp_target = shadow_next(fetch_pc);
            exp_hit    = shadow_valid[fetch_pc[`BTB_INDEX_BITS+1:2]];
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = '0;
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        lfsr_state     = 32'd92;
        model_cnt      = 0;
        gen_count      = 0;
        accepted       = 0;
        results        = 0;
        checks         = 0;
        errors         = 0;
        ready_low      = 0;
        burst_left     = 0;
        issued_last    = 1'b0;
        pushed_last    = 1'b0;
        lookup_pend    = 1'b0;
        exp_hit        = 1'b0;
        exp_target     = '0;
        for (int i = 0; i < `BTB_DEPTH; i++) begin
            shadow_valid[i]  = 1'b0;
            shadow_target[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        checks++;
        assert (!wb_valid && !pred_valid) else begin
            errors++;
            $display("ERROR @%0t: outputs active during reset", $time);
        end
        rst_n = 1'b1;
        for (int i = 0; i < 8; i++) begin
            run_cycle(1'b0);    // empty btb, every lookup misses.
        end
        cycles = 0;
        while ((gen_count < NUM_OPS || dispatch_valid) && cycles < DISPATCH_LIMIT) begin
            run_cycle(pick_offer());
            cycles++;
        end
        cycles = 0;
        while (pending.size() > 0 && cycles < DRAIN_LIMIT) begin
            run_cycle(1'b0);
            cycles++;
        end
        timed_out = (gen_count < NUM_OPS) || dispatch_valid || (pending.size() > 0);
        for (int i = 0; i < 8; i++) begin
            run_cycle(1'b0);
        end
        checks++;
        assert (results == accepted) else begin
            errors++;
            $display("ERROR @%0t: %0d results for %0d dispatches", $time, results, accepted);
        end
        $display("checks %0d, errors %0d, dispatched %0d, results %0d, ready low %0d cycles",
                 checks, errors, accepted, results, ready_low);
        if (timed_out) begin
            $display("operations were still outstanding when the wait limit ran out");
        end
        if (errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_branch_unit

`default_nettype wire

// File: tb.f
+incdir+source
+incdir+verif
source/rv32i_types.sv
source/br_issue_queue.sv
source/fu_br.sv
source/btb.sv
source/branch_predict.sv
source/br_writeback.sv
source/branch_unit_top.sv
verif/tb_branch_unit.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := tb.f
TOP        := tb_branch_unit
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_TEXT  := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
